/* common/cache_pkg.sv */
// Shared widths, operation type and port structs for the data cache
// Modules refer to these by scoped name, cache_pkg::name
package cache_pkg;

    // Word address width, one address per data word
    localparam int addr_width = 16;

    // Data word width on both the client and memory sides
    localparam int word_width = 32;

    // Client operation
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_t;

    // Client request, held stable while req is high
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        cache_op_t             op;
    } cpu_req_t;

    // Client response, valid while ack is high
    typedef struct packed {
        logic [word_width-1:0] rdata;
        // Set when the lookup found the line present
        logic                  hit;
    } cpu_rsp_t;

    // Backing memory request, one word per handshake
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        // Write enable, read when clear
        logic                  we;
    } mem_req_t;

endpackage

/* cache/tag_match.sv */
// Fully associative tag lookup for the data cache
// Compares one tag against every valid line and returns the lowest match
// Purely combinational, driven from the registered request in cache_ctrl
`timescale 1ns/1ps

module tag_match #(
    parameter int num_lines      = 4,
    parameter int words_per_line = 4
) (
    input  logic [cache_pkg::addr_width-$clog2(words_per_line)-1:0] lookup_tag,
    input  logic [num_lines-1:0][cache_pkg::addr_width-$clog2(words_per_line)-1:0] tags,
    input  logic [num_lines-1:0] valid,
    output logic hit,
    output logic [$clog2(num_lines)-1:0] hit_line
);

    localparam int idx_width = $clog2(num_lines);

    // One compare result per line
    logic [num_lines-1:0] match;

    // Comparator bank, an invalid line never matches
    always_comb begin
        for (int i = 0; i < num_lines; i++) begin
            match[i] = valid[i] && (tags[i] == lookup_tag);
        end
    end

    // Priority encoder
    // Scan from the top so the lowest matching line wins
    always_comb begin
        hit      = 1'b0;
        hit_line = '0;
        for (int i = num_lines - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit      = 1'b1;
                hit_line = idx_width'(i);
            end
        end
    end

endmodule

/* cache/lru_tracker.sv */
// Least recently used bookkeeping for the data cache
// Each line keeps an age, num_lines-1 is newest and 0 is the victim
// cache_ctrl pulses touch once per completed access
`timescale 1ns/1ps

module lru_tracker #(
    parameter int num_lines = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic touch,
    input  logic [$clog2(num_lines)-1:0] touch_line,
    output logic [$clog2(num_lines)-1:0] victim_line
);

    localparam int idx_width = $clog2(num_lines);

    // Ages always form a permutation of 0 .. num_lines-1
    logic [num_lines-1:0][idx_width-1:0] ages;

    // Age update
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Start with ages equal to the line index
            for (int i = 0; i < num_lines; i++) begin
                ages[i] <= idx_width'(i);
            end
        end else if (touch) begin
            for (int i = 0; i < num_lines; i++) begin
                if (idx_width'(i) == touch_line) begin
                    // Touched line becomes the newest
                    ages[i] <= idx_width'(num_lines - 1);
                end else if (ages[i] > ages[touch_line]) begin
                    // Lines newer than the touched one slide down by one
                    ages[i] <= ages[i] - 1'b1;
                end
            end
        end
    end

    // Victim is the single line at age zero
    always_comb begin
        victim_line = '0;
        for (int i = 0; i < num_lines; i++) begin
            if (ages[i] == '0) begin
                victim_line = idx_width'(i);
            end
        end
    end

endmodule

/* cache/cache_ctrl.sv */
// Data cache controller with tag, valid and data arrays
// Runs the client four-phase handshake, refills missed lines word by word
// and writes every store through to backing memory
// tag_match and lru_tracker sit beside it, wired up in cache_top
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int num_lines      = 4,
    parameter int words_per_line = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic ack,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output logic mreq,
    output cache_pkg::mem_req_t mem_req,
    input  logic mack,
    input  logic [cache_pkg::word_width-1:0] mem_rdata,
    output logic [cache_pkg::addr_width-$clog2(words_per_line)-1:0] lookup_tag,
    output logic [num_lines-1:0][cache_pkg::addr_width-$clog2(words_per_line)-1:0] tags,
    output logic [num_lines-1:0] valid,
    input  logic hit,
    input  logic [$clog2(num_lines)-1:0] hit_line,
    output logic touch,
    output logic [$clog2(num_lines)-1:0] touch_line,
    input  logic [$clog2(num_lines)-1:0] victim_line
);

    localparam int off_width = $clog2(words_per_line);
    localparam int tag_width = cache_pkg::addr_width - off_width;
    localparam int idx_width = $clog2(num_lines);

    typedef enum logic [2:0] {
        s_idle, s_lookup, s_mem_ack, s_mem_low, s_respond, s_done
    } state_t;

    state_t                            state;
    cache_pkg::cpu_req_t               req_q;
    logic [idx_width-1:0]              line_q;
    logic                              hit_q;
    logic [off_width-1:0]              cnt;
    // High while the memory handshake is a refill read
    logic                              fill_q;
    logic [cache_pkg::word_width-1:0]  data_arr [num_lines][words_per_line];
    logic [off_width-1:0]              req_off;
    logic                              is_write;
    logic                              word_done;
    logic                              fill_last;
    logic                              fill_start;
    logic                              fill_next;
    logic                              fill_end;
    logic                              wt_start;
    logic [off_width-1:0]              fill_off;

    // Request decode
    assign lookup_tag = req_q.addr[cache_pkg::addr_width-1:off_width];
    assign req_off    = req_q.addr[off_width-1:0];
    assign is_write   = (req_q.op == cache_pkg::op_write);

    // Memory sequencing events
    assign word_done  = (state == s_mem_low) && !mack;
    assign fill_last  = (cnt == off_width'(words_per_line - 1));
    assign fill_start = (state == s_lookup) && !hit;
    assign fill_next  = word_done && fill_q && !fill_last;
    assign fill_end   = word_done && fill_q && fill_last;
    assign wt_start   = ((state == s_lookup) && hit && is_write) || (fill_end && is_write);
    // Refill walks the line from its base address upward
    assign fill_off   = fill_start ? '0 : cnt + 1'b1;

    // LRU is told once per access, in the response cycle
    assign touch      = (state == s_respond);
    assign touch_line = line_q;

    // Control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= s_idle;
            ack    <= 1'b0;
            mreq   <= 1'b0;
            valid  <= '0;
            line_q <= '0;
            hit_q  <= 1'b0;
            cnt    <= '0;
            fill_q <= 1'b0;
        end else begin
            case (state)
                s_idle: if (req) state <= s_lookup;
                s_lookup: begin
                    // Lookup register
                    hit_q  <= hit;
                    line_q <= hit ? hit_line : victim_line;
                    if (!hit) begin
                        // Victim stays invalid until its refill is complete
                        valid[victim_line] <= 1'b0;
                        cnt    <= '0;
                        fill_q <= 1'b1;
                        mreq   <= 1'b1;
                        state  <= s_mem_ack;
                    end else if (is_write) begin
                        fill_q <= 1'b0;
                        mreq   <= 1'b1;
                        state  <= s_mem_ack;
                    end else begin
                        state <= s_respond;
                    end
                end
                s_mem_ack: if (mack) begin
                    mreq  <= 1'b0;
                    state <= s_mem_low;
                end
                // Wait for mack to fall before the next word or the response
                s_mem_low: if (!mack) begin
                    if (fill_next) begin
                        cnt   <= cnt + 1'b1;
                        mreq  <= 1'b1;
                        state <= s_mem_ack;
                    end else if (wt_start) begin
                        valid[line_q] <= 1'b1;
                        fill_q <= 1'b0;
                        mreq   <= 1'b1;
                        state  <= s_mem_ack;
                    end else begin
                        if (fill_end) valid[line_q] <= 1'b1;
                        state <= s_respond;
                    end
                end
                s_respond: begin
                    ack   <= 1'b1;
                    state <= s_done;
                end
                // Hold ack until the client drops req
                s_done: if (!req) begin
                    ack   <= 1'b0;
                    state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Request, arrays and bus payload
    always_ff @(posedge clk) begin
        if (state == s_idle && req) req_q <= cpu_req;
        if (fill_start || fill_next) begin
            mem_req.addr  <= {lookup_tag, fill_off};
            mem_req.wdata <= '0;
            mem_req.we    <= 1'b0;
        end else if (wt_start) begin
            mem_req.addr  <= req_q.addr;
            mem_req.wdata <= req_q.wdata;
            mem_req.we    <= 1'b1;
        end
        // Write hit updates the line before the write-through
        if (state == s_lookup && hit && is_write) data_arr[hit_line][req_off] <= req_q.wdata;
        if (state == s_mem_ack && mack && fill_q) data_arr[line_q][cnt] <= mem_rdata;
        if (fill_end) begin
            tags[line_q] <= tag_width'(lookup_tag);
            // Write miss merges the store into the fresh line
            if (is_write) data_arr[line_q][req_off] <= req_q.wdata;
        end
        // Response register, a write returns the stored word
        if (state == s_respond) begin
            cpu_rsp.rdata <= data_arr[line_q][req_off];
            cpu_rsp.hit   <= hit_q;
        end
    end

endmodule

/* src/backing_mem.sv */
// Word-addressed backing memory model behind a four-phase req/ack port
// mack rises two cycles after mreq is seen high and falls once mreq drops
// Each word starts out holding its address times 3 plus 1
`timescale 1ns/1ps

module backing_mem #(
    parameter int mem_words = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic mreq,
    input  cache_pkg::mem_req_t mem_req,
    output logic mack,
    output logic [cache_pkg::word_width-1:0] mem_rdata
);

    localparam int mem_aw = $clog2(mem_words);

    typedef enum logic [1:0] {m_idle, m_wait, m_access, m_hold} mstate_t;

    mstate_t                          mstate;
    logic [cache_pkg::word_width-1:0] mem [mem_words];
    logic [mem_aw-1:0]                maddr;

    // Only the low address bits select a word
    assign maddr = mem_req.addr[mem_aw-1:0];

    // Known starting contents
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = cache_pkg::word_width'(i * 3 + 1);
        end
    end

    // Handshake sequencing, fixed two-cycle ack delay
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mstate <= m_idle;
            mack   <= 1'b0;
        end else begin
            case (mstate)
                m_idle:   if (mreq) mstate <= m_wait;
                m_wait:   mstate <= m_access;
                m_access: begin
                    mack   <= 1'b1;
                    mstate <= m_hold;
                end
                m_hold: if (!mreq) begin
                    mack   <= 1'b0;
                    mstate <= m_idle;
                end
                default: mstate <= m_idle;
            endcase
        end
    end

    // Array access happens as mack rises
    always_ff @(posedge clk) begin
        if (mstate == m_access) begin
            if (mem_req.we) mem[maddr] <= mem_req.wdata;
            mem_rdata <= mem[maddr];
        end
    end

endmodule

/* src/cache_top.sv */
// Top level of the write-through data cache
// Connects the controller, tag lookup, LRU tracker and backing memory
// Clients use the req/ack port with one request in flight
`timescale 1ns/1ps

module cache_top #(
    parameter int num_lines      = 4,
    parameter int words_per_line = 4,
    parameter int mem_words      = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic ack,
    output cache_pkg::cpu_rsp_t cpu_rsp
);

    localparam int tag_width = cache_pkg::addr_width - $clog2(words_per_line);
    localparam int idx_width = $clog2(num_lines);

    logic [tag_width-1:0]                  lookup_tag;
    logic [num_lines-1:0][tag_width-1:0]   tags;
    logic [num_lines-1:0]                  valid;
    logic                                  hit;
    logic [idx_width-1:0]                  hit_line;
    logic                                  touch;
    logic [idx_width-1:0]                  touch_line;
    logic [idx_width-1:0]                  victim_line;
    logic                                  mreq;
    cache_pkg::mem_req_t                   mem_req;
    logic                                  mack;
    logic [cache_pkg::word_width-1:0]      mem_rdata;

    cache_ctrl #(.num_lines(num_lines), .words_per_line(words_per_line)) u_ctrl (
        .clk(clk), .reset(reset), .req(req), .cpu_req(cpu_req), .ack(ack), .cpu_rsp(cpu_rsp),
        .mreq(mreq), .mem_req(mem_req), .mack(mack), .mem_rdata(mem_rdata),
        .lookup_tag(lookup_tag), .tags(tags), .valid(valid), .hit(hit), .hit_line(hit_line),
        .touch(touch), .touch_line(touch_line), .victim_line(victim_line)
    );

    tag_match #(.num_lines(num_lines), .words_per_line(words_per_line)) u_match (
        .lookup_tag(lookup_tag), .tags(tags), .valid(valid), .hit(hit), .hit_line(hit_line)
    );

    lru_tracker #(.num_lines(num_lines)) u_lru (
        .clk(clk), .reset(reset), .touch(touch), .touch_line(touch_line),
        .victim_line(victim_line)
    );

    backing_mem #(.mem_words(mem_words)) u_mem (
        .clk(clk), .reset(reset), .mreq(mreq), .mem_req(mem_req), .mack(mack),
        .mem_rdata(mem_rdata)
    );

endmodule

/* verif/cache_tb.sv */
// Testbench for the write-through data cache
// Runs directed cold, hit, write and LRU sequences, then a random mix of accesses
// Every response is checked against a model of tags, valid bits, ages and memory
`timescale 1ns/1ps

module cache_tb;

    localparam int num_lines      = 4;
    localparam int words_per_line = 4;
    localparam int mem_words      = 256;
    localparam int off_width      = $clog2(words_per_line);
    localparam int tag_width      = cache_pkg::addr_width - off_width;
    localparam int mem_aw         = $clog2(mem_words);
    localparam int directed_txns  = 41;
    localparam int random_txns    = 400;
    // Five memory handshakes of six cycles, FSM overhead and client delays
    localparam int worst_latency  = 64;
    localparam int cycle_limit    = (directed_txns + random_txns) * worst_latency + 100;
    // Five distinct lines in 4 ways revisited in a mixed order
    localparam int lru_addrs [11] = '{48, 52, 56, 60, 64, 52, 48, 60, 56, 64, 52};

    logic                clk = 1'b0;
    logic                reset;
    logic                req;
    cache_pkg::cpu_req_t cpu_req;
    logic                ack;
    cache_pkg::cpu_rsp_t cpu_rsp;

    logic [31:0] rng_state   = 32'hea583e92;
    int          cycle_count = 0;

    // Reference model state
    logic [cache_pkg::word_width-1:0] model_mem [mem_words];
    logic [tag_width-1:0]             model_tag [num_lines];
    logic                             model_valid [num_lines];
    int                               model_age [num_lines];

    cache_top #(
        .num_lines(num_lines),
        .words_per_line(words_per_line),
        .mem_words(mem_words)
    ) DUT (
        .clk(clk), .reset(reset), .req(req), .cpu_req(cpu_req), .ack(ack), .cpu_rsp(cpu_rsp)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the cache did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // LCG step that returns the new state
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, got, expected);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Model of one access that updates tags, ages and memory
    task automatic model_access(input logic [15:0] addr, input logic is_wr,
                                input logic [31:0] wdata, output logic exp_hit,
                                output logic [31:0] exp_rdata);
        logic [tag_width-1:0] tag;
        int                   line;
        int                   old_age;
        tag     = addr[cache_pkg::addr_width-1:off_width];
        exp_hit = 1'b0;
        line    = 0;
        // Lowest valid line with a matching tag
        for (int i = 0; i < num_lines; i++) begin
            if (!exp_hit && model_valid[i] && model_tag[i] == tag) begin
                exp_hit = 1'b1;
                line    = i;
            end
        end
        // Miss refills the oldest line
        if (!exp_hit) begin
            for (int i = 0; i < num_lines; i++) begin
                if (model_age[i] == 0) line = i;
            end
            model_tag[line]   = tag;
            model_valid[line] = 1'b1;
        end
        old_age = model_age[line];
        for (int i = 0; i < num_lines; i++) begin
            if (i == line) model_age[i] = num_lines - 1;
            else if (model_age[i] > old_age) model_age[i] = model_age[i] - 1;
        end
        // Write-through keeps cache and memory equal
        if (is_wr) model_mem[addr[mem_aw-1:0]] = wdata;
        exp_rdata = model_mem[addr[mem_aw-1:0]];
    endtask

    // One full four-phase client transaction
    task automatic do_access(input logic [15:0] addr, input logic is_wr,
                             input logic [31:0] wdata, input int pre_delay,
                             input int hold_delay);
        logic        exp_hit;
        logic [31:0] exp_rdata;
        repeat (pre_delay) @(posedge clk);
        check_value(32'(ack), 32'd0, "ack low before req rises");
        model_access(addr, is_wr, wdata, exp_hit, exp_rdata);
        cpu_req.addr  <= addr;
        cpu_req.wdata <= wdata;
        cpu_req.op    <= is_wr ? cache_pkg::op_write : cache_pkg::op_read;
        req           <= 1'b1;
        do begin
            @(posedge clk);
        end while (!ack);
        check_value(32'(cpu_rsp.hit), 32'(exp_hit), $sformatf("hit flag at address %0h", addr));
        check_value(cpu_rsp.rdata, exp_rdata, $sformatf("rdata at address %0h", addr));
        // Ack and response hold until req falls
        repeat (hold_delay) begin
            @(posedge clk);
            check_value(32'(ack), 32'd1, "ack held while req is high");
            check_value(cpu_rsp.rdata, exp_rdata, "rdata stable while ack is high");
            check_value(32'(cpu_rsp.hit), 32'(exp_hit), "hit flag stable while ack is high");
        end
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack);
    endtask

    initial begin
        logic [31:0] r;
        reset   = 1'b1;
        req     = 1'b0;
        cpu_req = '0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = 32'(i * 3 + 1);
        end
        for (int i = 0; i < num_lines; i++) begin
            model_tag[i]   = '0;
            model_valid[i] = 1'b0;
            model_age[i]   = i;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Cold reads, one per line
        for (int i = 0; i < num_lines; i++) begin
            do_access(16'(i * words_per_line + i), 1'b0, 32'd0, 0, 0);
        end
        // Every word of the loaded lines hits
        for (int i = 0; i < num_lines * words_per_line; i++) begin
            do_access(16'(i), 1'b0, 32'd0, 0, 1);
        end

        // Write hit, write miss, then read back
        do_access(16'd6, 1'b1, next_random(), 0, 0);
        do_access(16'd100, 1'b1, next_random(), 1, 0);
        do_access(16'd100, 1'b0, 32'd0, 0, 0);
        do_access(16'd6, 1'b0, 32'd0, 0, 2);
        // Evict everything so the next reads refill from memory
        for (int i = 0; i < num_lines; i++) begin
            do_access(16'(128 + i * words_per_line), 1'b0, 32'd0, 0, 0);
        end
        do_access(16'd6, 1'b0, 32'd0, 0, 0);
        do_access(16'd100, 1'b0, 32'd0, 0, 0);

        // LRU replacement order
        for (int i = 0; i < 11; i++) begin
            do_access(16'(lru_addrs[i]), 1'b0, 32'd0, 0, 0);
        end

        // Random mix over a 64 word window
        for (int n = 0; n < random_txns; n++) begin
            r = next_random();
            do_access(16'(r[21:16]), r[27], next_random(), int'(r[31:30]), int'(r[29:28]));
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

/* build.f */
common/cache_pkg.sv
cache/tag_match.sv
cache/lru_tracker.sv
cache/cache_ctrl.sv
src/backing_mem.sv
src/cache_top.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/cache_sim 2>&1)
status=$?
echo "$sim_out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -qxF ">>> PASS"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
